// File: Makefile
# testbench top, the DUT is div_pipe_top below it
TOP := tb_div

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f

# exit status of the model is the test result
run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f tb.f
	verilator --lint-only --top-module div_pipe_top div_pkg.sv div_feed.sv \
		div_stage.sv div_drain.sv div_pipe_top.sv

clean:
	rm -rf obj_dir

// File: div_asserts.sv
`timescale 1ns/1ps

module div_asserts (
	input logic                 clk,
	input logic                 arst_n,
	input logic                 ena,
	input div_pkg::div_result_t res
);

	// whole output record clears with the async reset
	a_reset_clear : assert property (@(posedge clk) !arst_n |-> (res == '0))
		else $error("res not zero while arst_n is low");

	// a zero divisor is always an overflow as well
	a_div0_ovf : assert property (@(posedge clk) disable iff (!arst_n) res.div0 |-> res.ovf)
		else $error("div0 set without ovf");

	// stalled edge leaves the output alone
	a_hold : assert property (@(posedge clk) disable iff (!arst_n) !ena |=> $stable(res))
		else $error("res changed on an edge with ena low");

endmodule

bind div_pipe_top div_asserts u_asserts (
	.clk    (clk),
	.arst_n (arst_n),
	.ena    (ena),
	.res    (res)
);

// File: div_drain.sv
`timescale 1ns/1ps

module div_drain (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 ena,
	input  div_pkg::div_stage_t  stage_in,
	output div_pkg::div_result_t res
);

	logic                        rem_neg;  // last step overshot
	logic [div_pkg::R_WIDTH-1:0] rem_fix;  // corrected partial remainder
	logic [div_pkg::D_WIDTH-1:0] rem_out;  // remainder in output width
	div_pkg::div_result_t        res_next;

	assign rem_neg = stage_in.rem[div_pkg::Z_WIDTH];

	// A negative final remainder means the last subtract went too far.
	// The quotient bits are already right, only the remainder needs one add.
	always_comb
	begin
		if (rem_neg)
		begin
			rem_fix = stage_in.rem + stage_in.dvs;
		end
		else
		begin
			rem_fix = stage_in.rem;
		end
	end

	// remainder sits in the same bits as the aligned divisor
	assign rem_out = rem_fix[div_pkg::Z_WIDTH-1:div_pkg::Z_WIDTH-div_pkg::D_WIDTH];

	always_comb
	begin
		res_next.quo  = stage_in.quo;
		res_next.rem  = rem_out;
		res_next.div0 = stage_in.div0;
		res_next.ovf  = stage_in.ovf;
	end

	// output register
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			res <= '0; // flags low out of reset too
		end
		else if (ena)
		begin
			res <= res_next;
		end
	end

endmodule

// File: div_feed.sv
`timescale 1ns/1ps

module div_feed (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic                        ena,
	input  logic [div_pkg::Z_WIDTH-1:0] z,
	input  logic [div_pkg::D_WIDTH-1:0] d,
	output div_pkg::div_stage_t         stage_out
);

	logic [div_pkg::D_WIDTH-1:0] z_hi;       // upper half of the dividend
	logic                        d_zero;     // divide by zero
	logic                        q_too_wide; // quotient needs more than D_WIDTH bits
	div_pkg::div_stage_t         start_rec;  // record before the register

	assign z_hi = z[div_pkg::Z_WIDTH-1:div_pkg::Z_WIDTH-div_pkg::D_WIDTH];

	assign d_zero = (d == '0);

	// z / d fits in D_WIDTH bits only if z < d * 2**D_WIDTH,
	// which is the same as the upper half of z being below d.
	// A zero divisor always lands here as well, so div0 implies ovf.
	assign q_too_wide = (z_hi >= d);

	// start record of the recurrence
	always_comb
	begin
		start_rec.rem  = {1'b0, z}; // positive start, sign bit clear
		start_rec.dvs  = {1'b0, d, {div_pkg::ALIGN_PAD{1'b0}}};
		start_rec.quo  = '0;
		start_rec.div0 = d_zero;
		start_rec.ovf  = q_too_wide;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			stage_out <= '0;
		end
		else if (ena)
		begin
			stage_out <= start_rec; // operands enter the pipe here
		end
	end

endmodule

// File: div_pipe_top.sv
`timescale 1ns/1ps

module div_pipe_top (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic                        ena,
	input  logic [div_pkg::Z_WIDTH-1:0] z,
	input  logic [div_pkg::D_WIDTH-1:0] d,
	output div_pkg::div_result_t        res
);

	// Pipeline depth is D_WIDTH + 2 registers: feed, one per stage, drain.
	// Operands sampled on enabled edge k show up on res after edge k + D_WIDTH + 1.
	// Every register shares the same ena, so a low ena freezes the whole pipe.

	// stage_bus[0] from the feed block, stage_bus[D_WIDTH] into the drain
	div_pkg::div_stage_t stage_bus [div_pkg::D_WIDTH+1];

	div_feed u_feed (
		.clk       (clk),
		.arst_n    (arst_n),
		.ena       (ena),
		.z         (z),
		.d         (d),
		.stage_out (stage_bus[0])
	);

	// one quotient bit per stage, msb first
	for (genvar i = 0; i < div_pkg::D_WIDTH; i++)
	begin : g_stage
		div_stage u_stage (
			.clk       (clk),
			.arst_n    (arst_n),
			.ena       (ena),
			.stage_in  (stage_bus[i]),
			.stage_out (stage_bus[i+1])
		);
	end

	div_drain u_drain (
		.clk      (clk),
		.arst_n   (arst_n),
		.ena      (ena),
		.stage_in (stage_bus[div_pkg::D_WIDTH]),
		.res      (res)
	);

endmodule

// File: div_pkg.sv
package div_pkg;

	// operand widths
	// the quotient gets one bit per stage, so D_WIDTH is also the stage count
	localparam int Z_WIDTH = 16; // dividend
	localparam int D_WIDTH = 8;  // divisor, quotient, remainder

	// partial remainder carries one extra sign bit on top of the dividend
	localparam int R_WIDTH = Z_WIDTH + 1;

	// zero bits below the divisor when it is aligned under the dividend
	localparam int ALIGN_PAD = Z_WIDTH - D_WIDTH;

	// Record handed from the feed block down through every stage to the drain.
	// rem is two's complement, and bit Z_WIDTH is its sign.
	// dvs holds {1'b0, d, ALIGN_PAD zeros} and never changes along the pipe.
	// quo fills from the right, one bit per stage.
	typedef struct packed {
		logic [R_WIDTH-1:0] rem;  // partial remainder, msb is sign
		logic [R_WIDTH-1:0] dvs;  // left aligned divisor
		logic [D_WIDTH-1:0] quo;  // partial quotient
		logic               div0; // divisor was zero
		logic               ovf;  // quotient does not fit in D_WIDTH
	} div_stage_t;

	// result record at the pipeline output
	// quo and rem only mean something when both flags are low
	typedef struct packed {
		logic [D_WIDTH-1:0] quo;
		logic [D_WIDTH-1:0] rem;
		logic               div0;
		logic               ovf;
	} div_result_t;

endpackage

// File: div_stage.sv
`timescale 1ns/1ps

module div_stage (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                ena,
	input  div_pkg::div_stage_t stage_in,
	output div_pkg::div_stage_t stage_out
);

	logic [div_pkg::R_WIDTH-1:0] rem_shift;  // remainder times two
	logic [div_pkg::R_WIDTH-1:0] rem_next;   // after add or subtract
	logic                        rem_neg;    // sign of incoming remainder
	logic                        q_bit;      // new quotient bit
	div_pkg::div_stage_t         stage_next;

	assign rem_neg = stage_in.rem[div_pkg::Z_WIDTH];

	// The old sign bit drops out of the shift. The partial remainder always stays
	// within plus or minus dvs, so the result of the add or subtract below still
	// fits in R_WIDTH bits even though the shifted value alone may not.
	assign rem_shift = {stage_in.rem[div_pkg::Z_WIDTH-1:0], 1'b0};

	// non-restoring step, no restore on a negative result
	always_comb
	begin
		if (rem_neg)
		begin
			rem_next = rem_shift + stage_in.dvs; // undo overshoot of last step
		end
		else
		begin
			rem_next = rem_shift - stage_in.dvs;
		end
	end

	// quotient bit is one when the new remainder is not negative
	assign q_bit = ~rem_next[div_pkg::Z_WIDTH];

	always_comb
	begin
		stage_next.rem  = rem_next;
		stage_next.dvs  = stage_in.dvs;
		stage_next.quo  = {stage_in.quo[div_pkg::D_WIDTH-2:0], q_bit};
		stage_next.div0 = stage_in.div0;
		stage_next.ovf  = stage_in.ovf;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			stage_out <= '0;
		end
		else if (ena)
		begin
			stage_out <= stage_next;
		end
	end

endmodule

// File: tb.f
div_pkg.sv
div_feed.sv
div_stage.sv
div_drain.sv
div_pipe_top.sv
div_asserts.sv
tb_div.sv

// File: tb_div.sv
`timescale 1ns/1ps

module tb_div;

	localparam int CLK_PERIOD = 40;
	localparam int RST_CYCLES = 10;
	localparam int N_DIRECT = 9;
	localparam int N_RAND = 500;
	localparam int N_STALL = 300;
	localparam int N_OPS = N_DIRECT + N_RAND + N_STALL;
	localparam int WATCHDOG_NS = (N_OPS + 20) * CLK_PERIOD * 2;
	localparam int LATENCY = div_pkg::D_WIDTH + 1; // enabled edges from operands to res

	logic                        clk;
	logic                        arst_n;
	logic                        ena;
	logic [div_pkg::Z_WIDTH-1:0] z;
	logic [div_pkg::D_WIDTH-1:0] d;
	div_pkg::div_result_t        res;

	div_pkg::div_result_t exp_q [$]; // one entry per enabled edge, oldest first
	div_pkg::div_result_t res_prev;
	integer               seed;
	int                   n_issued;
	int                   n_checked;
	int                   n_holds;   // stalled edges seen

	div_pipe_top u_dut (
		.clk    (clk),
		.arst_n (arst_n),
		.ena    (ena),
		.z      (z),
		.d      (d),
		.res    (res)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	// plain integer division, flags from z >= d * 2**D_WIDTH
	function automatic div_pkg::div_result_t ref_div(
		input logic [div_pkg::Z_WIDTH-1:0] zv,
		input logic [div_pkg::D_WIDTH-1:0] dv
	);
		div_pkg::div_result_t                        r;
		logic [div_pkg::Z_WIDTH+div_pkg::D_WIDTH-1:0] z_wide;
		logic [div_pkg::Z_WIDTH+div_pkg::D_WIDTH-1:0] d_shift;
		logic [div_pkg::Z_WIDTH-1:0]                  d_ext;
		logic [div_pkg::Z_WIDTH-1:0]                  q_full;
		logic [div_pkg::Z_WIDTH-1:0]                  r_full;
		r = '0;
		z_wide = {{div_pkg::D_WIDTH{1'b0}}, zv};
		d_shift = {{(div_pkg::Z_WIDTH-div_pkg::D_WIDTH){1'b0}}, dv, {div_pkg::D_WIDTH{1'b0}}};
		d_ext = {{(div_pkg::Z_WIDTH-div_pkg::D_WIDTH){1'b0}}, dv};
		r.div0 = (dv == '0);
		r.ovf = (z_wide >= d_shift);
		if (!r.div0 && !r.ovf)
		begin
			q_full = zv / d_ext;
			r_full = zv % d_ext;
			r.quo = q_full[div_pkg::D_WIDTH-1:0];
			r.rem = r_full[div_pkg::D_WIDTH-1:0];
		end
		return r;
	endfunction

	task automatic report_mismatch(input string msg);
		$display("[ERROR] %0d ns: %s", $time, msg);
		$display("Test failures found");
		$fatal(1, "stopped at first mismatch");
	endtask

	// quo and rem only count when both flags are low
	task automatic check_result(
		input div_pkg::div_result_t exp,
		input div_pkg::div_result_t act,
		input string                what
	);
		if (act.div0 !== exp.div0 || act.ovf !== exp.ovf)
		begin
			report_mismatch($sformatf("%s flags expected div0=%b ovf=%b got div0=%b ovf=%b",
				what, exp.div0, exp.ovf, act.div0, act.ovf));
		end
		else if (!exp.div0 && !exp.ovf && (act.quo !== exp.quo || act.rem !== exp.rem))
		begin
			report_mismatch($sformatf("%s expected quo=%0d rem=%0d got quo=%0d rem=%0d",
				what, exp.quo, exp.rem, act.quo, act.rem));
		end
	endtask

	task automatic check_flag(input logic exp, input logic act, input string what);
		if (act !== exp)
		begin
			report_mismatch($sformatf("%s expected %b got %b", what, exp, act));
		end
	endtask

	// called at posedge + 2, returns at the next posedge + 2
	task automatic drive_cycle(
		input logic                        en,
		input logic [div_pkg::Z_WIDTH-1:0] zv,
		input logic [div_pkg::D_WIDTH-1:0] dv
	);
		ena = en;
		z = zv;
		d = dv;
		@(posedge clk);
		#2;
	endtask

	task automatic issue_op(
		input logic [div_pkg::Z_WIDTH-1:0] zv,
		input logic [div_pkg::D_WIDTH-1:0] dv
	);
		n_issued++;
		drive_cycle(1'b1, zv, dv);
	endtask

	// pipeline model, inputs taken at the edge and res read at the falling edge
	initial
	begin : compare_proc
		div_pkg::div_result_t exp;
		logic                 en_edge;
		forever
		begin
			@(posedge clk);
			en_edge = arst_n && ena;
			if (en_edge)
			begin
				exp_q.push_back(ref_div(z, d));
			end
			@(negedge clk);
			if (en_edge && exp_q.size() > LATENCY)
			begin
				exp = exp_q.pop_front();
				check_result(exp, res, "result");
				n_checked++;
			end
			else if (!en_edge && arst_n)
			begin
				check_flag(1'b1, res == res_prev, "res held while ena low");
				n_holds++;
			end
			res_prev = res;
		end
	end

	initial
	begin : stimulus
		div_pkg::div_result_t zero_res;
		logic [31:0]          rnd;
		int                   i;
		zero_res = '0;
		seed = 32'h944;
		n_issued = 0;
		n_checked = 0;
		n_holds = 0;
		arst_n = 1'b0;
		ena = 1'b0;
		z = '0;
		d = '0;
		repeat (RST_CYCLES) @(posedge clk);
		#2;
		arst_n = 1'b1;

		drive_cycle(1'b0, 16'h5555, 8'haa); // no enabled edge yet
		check_result(zero_res, res, "after reset");

		issue_op(16'd200, 8'd10);
		issue_op(16'd255, 8'd1);
		issue_op(16'd1000, 8'd7);
		issue_op(16'd12345, 8'd100);
		issue_op(16'hfeff, 8'hff); // largest quotient with a remainder
		issue_op(16'd0, 8'd5);
		issue_op(16'hffff, 8'hff);
		issue_op(16'd77, 8'd0);    // div0 and ovf
		issue_op(16'h1234, 8'h12); // ovf only

		// uniform z and d, so about half land in overflow
		for (i = 0; i < N_RAND; i++)
		begin
			rnd = $random(seed);
			issue_op(rnd[15:0], rnd[23:16]);
		end

		i = 0;
		while (i < N_STALL)
		begin
			rnd = $random(seed);
			if (rnd[6:0] < 7'd38)
			begin
				drive_cycle(1'b0, rnd[31:16], rnd[15:8]); // ~30% idle, inputs still move
			end
			else
			begin
				rnd = $random(seed);
				issue_op(rnd[15:0], rnd[23:16]);
				i++;
			end
		end

		while (n_checked < n_issued)
		begin
			drive_cycle(1'b1, '0, 8'd1); // flush
		end

		if (n_checked >= n_issued && n_holds > 0)
		begin
			$display("All tests passed!");
			$finish;
		end
		else
		begin
			$display("Test failures found");
			$fatal(1, "only %0d of %0d results checked", n_checked, n_issued);
		end
	end

	initial
	begin : watchdog
		#(WATCHDOG_NS);
		$display("run timed out after %0d ns, %0d of %0d results checked",
			WATCHDOG_NS, n_checked, n_issued);
		$display("Test failures found");
		$fatal(1, "watchdog expired");
	end

endmodule
